// ==== bench/dma_cases.txt ====
// DMA copy cases, one per line, all values hex
// Columns: source address, destination address, length in bytes, expected id
00000000 00000200 00000004 00000001
00000010 00000210 00000020 00000002
00000100 00000300 00000000 00000003
00000040 00000240 00000010 00000004
00000080 00000280 00000040 00000005
00000300 00000100 00000018 00000006
00000384 00000004 0000000c 00000007
000001c0 000003c0 00000000 00000008
000000c4 000002c8 00000028 00000009
00000200 00000000 00000080 0000000a
00000390 00000190 00000070 0000000b
00000004 000003fc 00000004 0000000c
// End marker, no case follows
ffffffff ffffffff ffffffff ffffffff

// ==== bench/dma_mem_model.sv ====
/*
 * Memory model
 * Word memory with one-cycle read latency, stalls driven from outside
 */

module dma_mem_model
  import dma_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         load_en_i,
  input  logic [$clog2(MEM_WORDS)-1:0] load_idx_i,
  input  data_t                        load_data_i,
  input  logic                         rd_stall_i,
  input  logic                         wr_stall_i,
  input  mem_rd_req_t                  rd_req_i,
  output logic                         rd_ready_o,
  output mem_rd_rsp_t                  rd_rsp_o,
  input  mem_wr_req_t                  wr_req_i,
  output logic                         wr_ready_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  data_t            mem_q [MEM_WORDS];
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  assign rd_ready_o = !rd_stall_i;
  assign wr_ready_o = !wr_stall_i;
  assign rd_idx     = rd_req_i.addr[IDX_W+1:2];
  assign wr_idx     = wr_req_i.addr[IDX_W+1:2];

  // Preload port only used before any job runs
  always_ff @(posedge clk_i) begin
    if (load_en_i) begin
      mem_q[load_idx_i] <= load_data_i;
    end else if (wr_req_i.valid && wr_ready_o) begin
      mem_q[wr_idx] <= wr_req_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_rsp_o <= '0;
    end else begin
      rd_rsp_o.valid <= rd_req_i.valid && rd_ready_o;
      rd_rsp_o.data  <= mem_q[rd_idx];
    end
  end

endmodule : dma_mem_model

// ==== bench/tb_dma.sv ====
/*
 * DMA testbench
 * Runs the copy jobs of the case file against a stalling memory model
 * and checks ids, status and memory contents
 */

`include "dma_settings.svh"

module tb_dma
  import dma_pkg::*;
();

  localparam int          MEM_WORDS = 256;
  localparam int          IDX_W     = $clog2(MEM_WORDS);
  localparam int          MAX_CASES = 32;
  localparam logic [15:0] LFSR_SEED = 16'd91;

  logic             clk;
  logic             rst_n;
  reg_req_t         reg_req;
  reg_rsp_t         reg_rsp;
  mem_rd_req_t      mem_rd_req;
  logic             mem_rd_ready;
  mem_rd_rsp_t      mem_rd_rsp;
  mem_wr_req_t      mem_wr_req;
  logic             mem_wr_ready;
  logic             load_en;
  logic [IDX_W-1:0] load_idx;
  data_t            load_data;
  logic             rd_stall;
  logic             wr_stall;

  logic [15:0] fill_state  = LFSR_SEED;
  logic [15:0] stall_state = LFSR_SEED;
  logic        watchdog_armed = 1'b0;
  int          watchdog_cycles;
  int          num_cases;
  int          total_words;
  data_t       shadow [MEM_WORDS];
  logic [31:0] case_words [MAX_CASES*4];

  dma_core_wrap dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .reg_req_i      ( reg_req      ),
    .reg_rsp_o      ( reg_rsp      ),
    .mem_rd_req_o   ( mem_rd_req   ),
    .mem_rd_ready_i ( mem_rd_ready ),
    .mem_rd_rsp_i   ( mem_rd_rsp   ),
    .mem_wr_req_o   ( mem_wr_req   ),
    .mem_wr_ready_i ( mem_wr_ready )
  );

  dma_mem_model #(.MEM_WORDS(MEM_WORDS)) i_mem_model (
    .clk_i       ( clk          ),
    .rst_n_i     ( rst_n        ),
    .load_en_i   ( load_en      ),
    .load_idx_i  ( load_idx     ),
    .load_data_i ( load_data    ),
    .rd_stall_i  ( rd_stall     ),
    .wr_stall_i  ( wr_stall     ),
    .rd_req_i    ( mem_rd_req   ),
    .rd_ready_o  ( mem_rd_ready ),
    .rd_rsp_o    ( mem_rd_rsp   ),
    .wr_req_i    ( mem_wr_req   ),
    .wr_ready_o  ( mem_wr_ready )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  task automatic check_equal(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s, got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped at the first error");
    end
  endtask

  // Called after a falling edge, returns after the falling edge that shows the response
  task automatic access_register(input logic write, input reg_addr_t addr,
                                 input data_t wdata, output data_t rdata);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    do begin
      @(negedge clk);
    end while (!reg_rsp.valid);
    rdata         = reg_rsp.rdata;
    reg_req.valid = 1'b0;
  endtask

  task automatic load_cases();
    for (int i = 0; i < MAX_CASES * 4; i++) begin
      case_words[i] = 32'hffff_ffff;
    end
    $readmemh("bench/dma_cases.txt", case_words);
    num_cases   = 0;
    total_words = 0;
    while (num_cases < MAX_CASES && case_words[4*num_cases] != 32'hffff_ffff) begin
      total_words += int'(case_words[4*num_cases+2] >> 2);
      num_cases++;
    end
  endtask

  task automatic compare_memory(input int case_no);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_equal(i_mem_model.mem_q[i], shadow[i],
                  $sformatf("memory word at 0x%03h after case %0d", i * 4, case_no));
    end
  endtask

  // Random read and write stalls, two bits per cycle
  always @(negedge clk) begin
    logic [31:0] bits;
    draw_bits(stall_state, 2, bits);
    rd_stall = bits[1];
    wr_stall = bits[0];
  end

  initial begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the DMA did not finish the cases within %0d cycles", watchdog_cycles);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  initial begin
    data_t       rdata;
    data_t       src;
    data_t       dst;
    data_t       len_bytes;
    data_t       exp_id;
    logic [31:0] fill_word;
    int          words;

    rst_n     = 1'b0;
    reg_req   = '0;
    load_en   = 1'b0;
    load_idx  = '0;
    load_data = '0;
    rd_stall  = 1'b0;
    wr_stall  = 1'b0;

    load_cases();
    if (num_cases == 0) begin
      $display("No test cases were found in bench/dma_cases.txt");
      $display("FAIL: see errors above");
      $fatal(1, "empty case file");
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Preload memory and keep the shadow copy
    for (int i = 0; i < MEM_WORDS; i++) begin
      draw_bits(fill_state, 32, fill_word);
      shadow[i] = fill_word;
      load_en   = 1'b1;
      load_idx  = IDX_W'(i);
      load_data = fill_word;
      @(negedge clk);
    end
    load_en = 1'b0;

    watchdog_cycles = 200 + 20 * total_words;
    watchdog_armed  = 1'b1;

    access_register(1'b0, `DMA_REG_DONE_ID, '0, rdata);
    check_equal(rdata, '0, "DONE_ID after reset");
    access_register(1'b0, `DMA_REG_STATUS, '0, rdata);
    check_equal(rdata, '0, "STATUS after reset");

    for (int c = 0; c < num_cases; c++) begin
      src       = case_words[4*c];
      dst       = case_words[4*c+1];
      len_bytes = case_words[4*c+2];
      exp_id    = case_words[4*c+3];
      words     = int'(len_bytes >> 2);

      access_register(1'b1, `DMA_REG_SRC, src, rdata);
      access_register(1'b1, `DMA_REG_DST, dst, rdata);
      access_register(1'b1, `DMA_REG_LEN, len_bytes, rdata);
      access_register(1'b0, `DMA_REG_NEXT_ID, '0, rdata);
      check_equal(rdata, exp_id, $sformatf("NEXT_ID of case %0d", c));

      if (words == 0) begin
        access_register(1'b0, `DMA_REG_DONE_ID, '0, rdata);
        check_equal(rdata, exp_id, $sformatf("DONE_ID after empty case %0d", c));
      end else begin
        access_register(1'b0, `DMA_REG_STATUS, '0, rdata);
        check_equal(rdata, 32'd1, $sformatf("STATUS while case %0d runs", c));
        do begin
          access_register(1'b0, `DMA_REG_DONE_ID, '0, rdata);
        end while (rdata != exp_id);
        for (int w = 0; w < words; w++) begin
          shadow[int'(dst >> 2) + w] = shadow[int'(src >> 2) + w];
        end
      end

      access_register(1'b0, `DMA_REG_STATUS, '0, rdata);
      check_equal(rdata, '0, $sformatf("STATUS after case %0d", c));
      compare_memory(c);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule : tb_dma

// ==== flist.f ====
+incdir+source
source/dma_pkg.sv
source/dma_reg_frontend.sv
source/dma_data_buffer.sv
source/dma_backend.sv
source/dma_core_wrap.sv
bench/dma_mem_model.sv
bench/tb_dma.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_dma -f flist.f -o sim_tb_dma

./obj_dir/sim_tb_dma

// ==== source/dma_backend.sv ====
/*
 * DMA backend
 * Copies a job word by word with pipelined reads, buffered data
 * and independent writes, then signals completion
 */

`include "dma_settings.svh"

module dma_backend
  import dma_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dma_job_t    job_i,
  input  logic        job_valid_i,
  output logic        job_ready_o,
  output logic        job_done_o,
  output logic        busy_o,
  output mem_rd_req_t mem_rd_req_o,
  input  logic        mem_rd_ready_i,
  input  mem_rd_rsp_t mem_rd_rsp_i,
  output mem_wr_req_t mem_wr_req_o,
  input  logic        mem_wr_ready_i
);

  backend_state_e state_q;
  addr_t          rd_addr_q;
  addr_t          wr_addr_q;
  len_t           rd_left_q;
  len_t           wr_left_q;
  len_t           job_words;
  buf_cnt_t       inflight_q;
  buf_cnt_t       buf_count;
  data_t          buf_data;
  logic           buf_empty;
  logic           job_done_q;
  logic           job_fire;
  logic           rd_credit;
  logic           rd_fire;
  logic           wr_fire;

  assign job_ready_o = (state_q == IDLE);
  assign job_fire    = job_valid_i && job_ready_o;
  assign job_words   = {2'b00, job_i.len[`DMA_LEN_W-1:2]};

  // Every read must find a free slot when its data comes back
  assign rd_credit = (buf_count + inflight_q) < `DMA_BUF_DEPTH;

  assign mem_rd_req_o.valid = (state_q == COPY) && rd_credit;
  assign mem_rd_req_o.addr  = rd_addr_q;
  assign rd_fire            = mem_rd_req_o.valid && mem_rd_ready_i;

  assign mem_wr_req_o.valid = (state_q != IDLE) && !buf_empty;
  assign mem_wr_req_o.addr  = wr_addr_q;
  assign mem_wr_req_o.data  = buf_data;
  assign wr_fire            = mem_wr_req_o.valid && mem_wr_ready_i;

  dma_data_buffer i_data_buffer (
    .clk_i,
    .rst_n_i,
    .push_i      ( mem_rd_rsp_i.valid ),
    .push_data_i ( mem_rd_rsp_i.data  ),
    .pop_i       ( wr_fire            ),
    .pop_data_o  ( buf_data           ),
    .count_o     ( buf_count          ),
    .empty_o     ( buf_empty          )
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      inflight_q <= '0;
      job_done_q <= 1'b0;
    end else begin
      job_done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (job_fire) begin
            state_q <= COPY;
          end
        end
        COPY: begin
          // Last read issued
          if (rd_fire && rd_left_q == len_t'(1)) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          if (wr_fire && wr_left_q == len_t'(1)) begin
            state_q    <= IDLE;
            job_done_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase

      case ({rd_fire, mem_rd_rsp_i.valid})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Address walkers and word counters, loaded per job
  always_ff @(posedge clk_i) begin
    if (job_fire) begin
      rd_addr_q <= job_i.src;
      wr_addr_q <= job_i.dst;
      rd_left_q <= job_words;
      wr_left_q <= job_words;
    end else begin
      if (rd_fire) begin
        rd_addr_q <= rd_addr_q + addr_t'(`DMA_DATA_W / 8);
        rd_left_q <= rd_left_q - 1'b1;
      end
      if (wr_fire) begin
        wr_addr_q <= wr_addr_q + addr_t'(`DMA_DATA_W / 8);
        wr_left_q <= wr_left_q - 1'b1;
      end
    end
  end

  assign job_done_o = job_done_q;
  // Held through the done pulse so the frontend sees completions in order
  assign busy_o     = (state_q != IDLE) || job_done_q;

  a_rsp_has_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rd_rsp_i.valid |-> inflight_q != '0);

endmodule : dma_backend

// ==== source/dma_core_wrap.sv ====
/*
 * DMA core wrapper
 * Register frontend and copy backend behind one register port
 * and one memory master port
 */

module dma_core_wrap
  import dma_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  output mem_rd_req_t mem_rd_req_o,
  input  logic        mem_rd_ready_i,
  input  mem_rd_rsp_t mem_rd_rsp_i,
  output mem_wr_req_t mem_wr_req_o,
  input  logic        mem_wr_ready_i
);

  dma_job_t job;
  logic     job_valid;
  logic     job_ready;
  logic     job_done;
  logic     backend_busy;

  dma_reg_frontend i_dma_frontend (
    .clk_i,
    .rst_n_i,
    .reg_req_i      ( reg_req_i    ),
    .reg_rsp_o      ( reg_rsp_o    ),
    // Job handshake to the backend
    .job_o          ( job          ),
    .job_valid_o    ( job_valid    ),
    .job_ready_i    ( job_ready    ),
    .job_done_i     ( job_done     ),
    .backend_busy_i ( backend_busy )
  );

  dma_backend i_dma_backend (
    .clk_i,
    .rst_n_i,
    .job_i          ( job            ),
    .job_valid_i    ( job_valid      ),
    .job_ready_o    ( job_ready      ),
    .job_done_o     ( job_done       ),
    .busy_o         ( backend_busy   ),
    .mem_rd_req_o   ( mem_rd_req_o   ),
    .mem_rd_ready_i ( mem_rd_ready_i ),
    .mem_rd_rsp_i   ( mem_rd_rsp_i   ),
    .mem_wr_req_o   ( mem_wr_req_o   ),
    .mem_wr_ready_i ( mem_wr_ready_i )
  );

endmodule : dma_core_wrap

// ==== source/dma_data_buffer.sv ====
/*
 * DMA data buffer
 * Small FIFO between the read and write sides of the backend
 */

`include "dma_settings.svh"

module dma_data_buffer
  import dma_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  data_t    push_data_i,
  input  logic     pop_i,
  output data_t    pop_data_o,
  output buf_cnt_t count_o,
  output logic     empty_o
);

  data_t    mem_q [`DMA_BUF_DEPTH];
  buf_ptr_t wr_ptr_q;
  buf_ptr_t rd_ptr_q;
  buf_cnt_t count_q;

  function automatic buf_ptr_t ptr_inc(buf_ptr_t ptr);
    return (ptr == buf_ptr_t'(`DMA_BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Head of queue, read without latency
  assign pop_data_o = mem_q[rd_ptr_q];
  assign count_o    = count_q;
  assign empty_o    = (count_q == '0);

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> count_q < `DMA_BUF_DEPTH);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule : dma_data_buffer

// ==== source/dma_pkg.sv ====
/*
 * DMA package
 * Shared types for the register bus, jobs and memory channels
 */

`include "dma_settings.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0]     addr_t;
  typedef logic [`DMA_DATA_W-1:0]     data_t;
  typedef logic [`DMA_LEN_W-1:0]      len_t;
  typedef logic [`DMA_ID_W-1:0]       job_id_t;
  typedef logic [`DMA_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`DMA_BUF_PTR_W-1:0]  buf_ptr_t;
  typedef logic [`DMA_BUF_CNT_W-1:0]  buf_cnt_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    data_t     wdata;
  } reg_req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
  } reg_rsp_t;

  // Byte addresses, length in bytes
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } dma_job_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } mem_wr_req_t;

  typedef enum logic [1:0] {
    IDLE,
    COPY,
    DRAIN
  } backend_state_e;

endpackage : dma_pkg

// ==== source/dma_reg_frontend.sv ====
/*
 * DMA register frontend
 * Holds source, destination and length, launches jobs on a NEXT_ID read
 * and tracks the id of the last completed job
 */

`include "dma_settings.svh"

module dma_reg_frontend
  import dma_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output dma_job_t job_o,
  output logic     job_valid_o,
  input  logic     job_ready_i,
  input  logic     job_done_i,
  input  logic     backend_busy_i
);

  addr_t   src_q;
  addr_t   dst_q;
  len_t    len_q;
  job_id_t next_id_q;
  job_id_t done_id_q;
  logic    job_valid_q;
  logic    zero_wait_q;
  logic    rsp_valid_q;
  data_t   rdata_q;
  data_t   rd_mux;
  logic    accept;
  logic    launch;
  logic    zero_done;
  logic    id_rsp;
  logic    busy;

  // One access at a time, nothing new while an id is outstanding
  assign accept    = reg_req_i.valid && !rsp_valid_q && !job_valid_q && !zero_wait_q;
  assign launch    = accept && !reg_req_i.write && (reg_req_i.addr == `DMA_REG_NEXT_ID);
  // Empty jobs finish once the backend has retired everything before them
  assign zero_done = zero_wait_q && !backend_busy_i;
  assign id_rsp    = (job_valid_q && job_ready_i) || zero_done;
  assign busy      = backend_busy_i || job_valid_q || zero_wait_q;

  always_comb begin
    case (reg_req_i.addr)
      `DMA_REG_SRC:     rd_mux = src_q;
      `DMA_REG_DST:     rd_mux = dst_q;
      `DMA_REG_LEN:     rd_mux = data_t'(len_q);
      `DMA_REG_NEXT_ID: rd_mux = data_t'(next_id_q);
      `DMA_REG_DONE_ID: rd_mux = data_t'(done_id_q);
      `DMA_REG_STATUS:  rd_mux = data_t'(busy);
      default:          rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q       <= '0;
      dst_q       <= '0;
      len_q       <= '0;
      next_id_q   <= job_id_t'(1);
      done_id_q   <= '0;
      job_valid_q <= 1'b0;
      zero_wait_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= (accept && !launch) || id_rsp;

      if (accept && reg_req_i.write) begin
        case (reg_req_i.addr)
          `DMA_REG_SRC: src_q <= reg_req_i.wdata;
          `DMA_REG_DST: dst_q <= reg_req_i.wdata;
          `DMA_REG_LEN: len_q <= reg_req_i.wdata[`DMA_LEN_W-1:0];
          default: ;
        endcase
      end

      if (launch) begin
        if (len_q == '0) begin
          zero_wait_q <= 1'b1;
        end else begin
          job_valid_q <= 1'b1;
        end
      end

      if (job_valid_q && job_ready_i) begin
        job_valid_q <= 1'b0;
      end

      if (id_rsp) begin
        next_id_q <= next_id_q + 1'b1;
      end

      if (zero_done) begin
        zero_wait_q <= 1'b0;
        done_id_q   <= next_id_q;
      end else if (job_done_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
    end
  end

  // Launch captures the id that the delayed response returns
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_mux;
    end
  end

  assign reg_rsp_o.valid = rsp_valid_q;
  assign reg_rsp_o.rdata = rdata_q;

  assign job_o.src   = src_q;
  assign job_o.dst   = dst_q;
  assign job_o.len   = len_q;
  assign job_valid_o = job_valid_q;

  a_job_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    job_valid_o && !job_ready_i |=> job_valid_o && $stable(job_o));

endmodule : dma_reg_frontend

// ==== source/dma_settings.svh ====
/*
 * DMA settings
 * Widths, data buffer depth and register word offsets
 */

`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_LEN_W       16
`define DMA_ID_W        8

// Data buffer, pointer and count widths follow the depth
`define DMA_BUF_DEPTH   4
`define DMA_BUF_PTR_W   2
`define DMA_BUF_CNT_W   3

`define DMA_REG_ADDR_W  3
`define DMA_REG_SRC     3'd0
`define DMA_REG_DST     3'd1
`define DMA_REG_LEN     3'd2
`define DMA_REG_NEXT_ID 3'd3
`define DMA_REG_DONE_ID 3'd4
`define DMA_REG_STATUS  3'd5

`endif
